// File: filelist.f
+incdir+hdl
hdl/rnd_pkg.sv
hdl/rnd_ifs.sv
hdl/rnd_issue_queue.sv
hdl/rnd_fp_path.sv
hdl/rnd_int_path.sv
hdl/rnd_result_pack.sv
hdl/rnd_top.sv
verification/tb_rnd_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_rnd_top
RTL_TOP   = rnd_top
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_rnd_top.sv
`include "rnd_defs.svh"

module tb_rnd_top;

  // cycles any single wait may take
  localparam int TIMEOUT = 500;
  // flag bit positions from inv down to zer
  localparam int F_INV = 5;
  localparam int F_INE = 4;
  localparam int F_OVF = 3;
  localparam int F_UNF = 2;
  localparam int F_INF = 1;
  localparam int F_ZER = 0;

  logic                      cpu_clk;
  logic                      rst_n_i;
  logic                      in_valid_i;
  logic                      in_kind_i;
  logic [1:0]                in_mode_i;
  logic                      in_sign_i;
  logic [`RND_EXP_INT_W-1:0] in_exp_i;
  logic                      in_shl_i;
  logic [`RND_SH_W-1:0]      in_shift_i;
  logic [`RND_INT_W+1:0]     in_payload_i;
  logic                      in_credit_o;
  logic                      out_valid_o;
  logic [`RND_INT_W-1:0]     out_result_o;
  logic [5:0]                out_flags_o;
  logic                      out_credit_i;

  // expected {flags, word} in issue order and the test that sent it
  logic [37:0] exp_q [$];
  string       name_q [$];
  // cycle at which each freed result gives its credit back
  int          due_q [$];
  int          prod_credits;
  int          pops;
  int          returns;
  int          sent;
  int          cyc;
  integer      seed;
  string       cur_test;

  rnd_top u_rnd_top (.*);

  always #20 cpu_clk = ~cpu_clk;

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(string test, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("FAIL %s expected %0h actual %0h", test, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // round away from the truncated value or not
  function automatic logic mode_says_up(logic [1:0] mode, logic sign, logic lsb,
                                        logic r, logic s);
    case (mode)
      2'd0:    return r && (s || lsb);
      2'd1:    return 1'b0;
      2'd2:    return !sign && (r || s);
      default: return sign && (r || s);
    endcase
  endfunction

  function automatic logic [37:0] float_expected(logic [1:0] mode, logic sign,
                                                 logic [9:0] exp, logic shl,
                                                 logic [4:0] shift, logic [33:0] payload);
    logic [63:0] frac;
    logic [63:0] v;
    logic [63:0] lost_mask;
    logic [63:0] sig;
    logic        r;
    logic        s;
    logic [10:0] e;
    logic [5:0]  flags;
    logic [31:0] word;
    // sig, round, sticky in the low 26 bits
    frac = {38'd0, payload[25:0]};
    if (shl) begin
      v = (frac << shift) & 64'h3ff_ffff;
      r = 1'b0;
      s = 1'b0;
    end else begin
      v         = frac >> shift;
      lost_mask = (64'd1 << shift) - 64'd1;
      r         = v[1];
      s         = v[0] | ((frac & lost_mask) != 64'd0);
    end
    sig = v >> 2;
    sig = sig + {63'd0, mode_says_up(mode, sign, sig[0], r, s)};
    e   = {1'b0, exp};
    // 1.111.. rounded up becomes 1.0 one binade higher
    if (sig[24]) begin
      sig = sig >> 1;
      e   = e + 11'd1;
    end
    flags        = '0;
    flags[F_INE] = r | s;
    if (e > 11'(`RND_EXP_MAX)) begin
      word         = {sign, 8'hff, 23'd0};
      flags[F_OVF] = 1'b1;
      flags[F_INF] = 1'b1;
      flags[F_INE] = 1'b1;
    end else if (!sig[23]) begin
      word         = {sign, 8'd0, sig[22:0]};
      flags[F_UNF] = r | s;
      flags[F_ZER] = (sig[23:0] == 24'd0);
    end else begin
      word = {sign, e[7:0], sig[22:0]};
    end
    return {flags, word};
  endfunction

  function automatic logic [37:0] int_expected(logic [1:0] mode, logic sign, logic [4:0] shift,
                                               logic [33:0] payload);
    logic [63:0] full;
    logic [63:0] v;
    logic [63:0] mag;
    logic        r;
    logic        s;
    logic        bad;
    logic [31:0] word;
    logic [5:0]  flags;
    full = {30'd0, payload};
    v    = full >> shift;
    r    = v[1];
    s    = v[0] | ((full & ((64'd1 << shift) - 64'd1)) != 64'd0);
    mag  = v >> 2;
    mag  = mag + {63'd0, mode_says_up(mode, sign, mag[0], r, s)};
    // int32 covers -2^31 up to 2^31-1
    bad  = sign ? (mag > 64'h8000_0000) : (mag > 64'h7fff_ffff);
    if (bad) begin
      word = sign ? 32'h8000_0000 : 32'h7fff_ffff;
    end else if (sign) begin
      word = 32'd0 - mag[31:0];
    end else begin
      word = mag[31:0];
    end
    flags        = '0;
    flags[F_INV] = bad;
    flags[F_INE] = r | s;
    flags[F_ZER] = (word == 32'd0);
    return {flags, word};
  endfunction

  function automatic logic [33:0] fp_payload(logic [23:0] sig, logic r, logic s);
    return {8'd0, sig, r, s};
  endfunction

  function automatic logic [33:0] int_payload(logic [31:0] mag, logic r, logic s);
    return {mag, r, s};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // producer and consumer
  ////////////////////////////////////////////////////////////////////////////

  // one operand per call and one input credit spent
  task automatic send_op(logic kind, logic [1:0] mode, logic sign, logic [9:0] exp,
                         logic shl, logic [4:0] shift, logic [33:0] payload);
    int waited;
    waited = 0;
    while (prod_credits == 0) begin
      @(posedge cpu_clk);
      in_valid_i <= 1'b0;
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure("no input credit came back from the DUT in time");
      end
    end
    @(posedge cpu_clk);
    in_valid_i   <= 1'b1;
    in_kind_i    <= kind;
    in_mode_i    <= mode;
    in_sign_i    <= sign;
    in_exp_i     <= exp;
    in_shl_i     <= shl;
    in_shift_i   <= shift;
    in_payload_i <= payload;
    prod_credits--;
    sent++;
    exp_q.push_back(kind ? int_expected(mode, sign, shift, payload)
                         : float_expected(mode, sign, exp, shl, shift, payload));
    name_q.push_back(cur_test);
  endtask

  // idle until every result is back and its output credit returned
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(posedge cpu_clk);
    in_valid_i <= 1'b0;
    while (exp_q.size() != 0 || returns != sent) begin
      @(posedge cpu_clk);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure("results did not come back from the DUT in time");
      end
    end
  endtask

  // sample mid-cycle where outputs are settled
  always @(negedge cpu_clk) begin
    if (rst_n_i) begin
      if (in_credit_o) begin
        prod_credits++;
        pops++;
      end
      if (out_credit_i) begin
        returns++;
      end
      if (pops - returns > `RND_OUT_CREDITS) begin
        stop_with_failure("more results outstanding than the DUT has output credits");
      end
      if (out_valid_o) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("DUT produced a result that was never requested");
        end
        check_value(name_q[0], 64'(exp_q[0]), 64'({out_flags_o, out_result_o}));
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
        // consumer frees it 0 to 3 cycles later
        due_q.push_back(cyc + 1 + int'({$random(seed)} % 4));
      end
    end
  end

  // at most one credit pulse per cycle
  always @(posedge cpu_clk) begin
    cyc = cyc + 1;
    if (rst_n_i && due_q.size() != 0 && due_q[0] <= cyc) begin
      out_credit_i <= 1'b1;
      void'(due_q.pop_front());
    end else begin
      out_credit_i <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic exact_floats();
    cur_test = "exact";
    // 1.5 and a plain negative normal
    send_op(1'b0, 2'd0, 1'b0, 10'd127, 1'b0, 5'd0, fp_payload(24'hc00000, 1'b0, 1'b0));
    send_op(1'b0, 2'd1, 1'b1, 10'd130, 1'b0, 5'd0, fp_payload(24'ha5a5a4, 1'b0, 1'b0));
    // right shift into a denormal with only zeros falling off
    send_op(1'b0, 2'd0, 1'b0, 10'd0, 1'b0, 5'd4, fp_payload(24'h800000, 1'b0, 1'b0));
    // left shift normalizes and r and s join the significand
    send_op(1'b0, 2'd2, 1'b0, 10'd100, 1'b1, 5'd2, fp_payload(24'h200000, 1'b1, 1'b1));
    send_op(1'b0, 2'd3, 1'b1, 10'd1, 1'b1, 5'd8, fp_payload(24'h008000, 1'b0, 1'b0));
    wait_drained();
  endtask

  task automatic rounding_modes();
    logic [23:0] sig;
    logic        r;
    logic        s;
    cur_test = "modes";
    for (int m = 0; m < 4; m++) begin
      for (int sg = 0; sg < 2; sg++) begin
        // half with even lsb, half with odd lsb, above half, below half
        for (int c = 0; c < 4; c++) begin
          sig = (c == 1) ? 24'ha00001 : 24'ha00000;
          r   = (c != 3);
          s   = (c >= 2);
          send_op(1'b0, 2'(m), 1'(sg), 10'd140, 1'b0, 5'd0, fp_payload(sig, r, s));
        end
      end
      // all ones where a round up carries into the exponent
      send_op(1'b0, 2'(m), (m == 3), 10'd131, 1'b0, 5'd0,
              fp_payload(24'hffffff, 1'b1, 1'b1));
    end
    wait_drained();
  endtask

  task automatic exponent_range();
    cur_test = "range";
    for (int m = 0; m < 4; m++) begin
      // carry out of the top binade
      send_op(1'b0, 2'(m), 1'b0, 10'd254, 1'b0, 5'd0, fp_payload(24'hffffff, 1'b1, 1'b1));
      // exponent already past the finite range
      send_op(1'b0, 2'(m), 1'b1, 10'd300, 1'b0, 5'd0, fp_payload(24'h800000, 1'b0, 1'b0));
      // everything shifted into sticky
      send_op(1'b0, 2'(m), (m == 3), 10'd0, 1'b0, 5'd26, fp_payload(24'h000123, 1'b0, 1'b0));
      // denormal sitting on a halfway point
      send_op(1'b0, 2'(m), 1'b0, 10'd0, 1'b0, 5'd3, fp_payload(24'h40000c, 1'b0, 1'b0));
      send_op(1'b0, 2'(m), 1'b1, 10'd0, 1'b0, 5'd0, fp_payload(24'd0, 1'b0, 1'b0));
    end
    wait_drained();
  endtask

  task automatic int_conversion();
    cur_test = "convert";
    for (int m = 0; m < 4; m++) begin
      for (int sg = 0; sg < 2; sg++) begin
        // 5.5 and 6.5 ties, 5.75 above, 5.25 below
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd1, int_payload(32'd11, 1'b0, 1'b0));
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd1, int_payload(32'd13, 1'b0, 1'b0));
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd0, int_payload(32'd5, 1'b1, 1'b1));
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd0, int_payload(32'd5, 1'b0, 1'b1));
        // limits at 2^31 and rounding across 2^31-1
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd0,
                int_payload(32'h8000_0000, 1'b0, 1'b0));
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd0,
                int_payload(32'h7fff_ffff, 1'b1, 1'b1));
        send_op(1'b1, 2'(m), 1'(sg), 10'd0, 1'b0, 5'd31,
                int_payload(32'hffff_ffff, 1'b1, 1'b1));
      end
    end
    wait_drained();
  endtask

  task automatic credit_burst();
    int start_pops;
    cur_test   = "burst";
    start_pops = pops;
    // back to back with alternating kinds and random fields
    for (int i = 0; i < 12; i++) begin
      send_op(1'(i % 2), 2'($random(seed)), 1'($random(seed)),
              10'(({$random(seed)} % 254) + 1), 1'($random(seed)),
              5'({$random(seed)} % 8), 34'({$random(seed), $random(seed)}));
    end
    wait_drained();
    check_value("burst credits", 64'(12), 64'(pops - start_pops));
  endtask

  initial begin
    cpu_clk      = 1'b0;
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    in_kind_i    = 1'b0;
    in_mode_i    = 2'd0;
    in_sign_i    = 1'b0;
    in_exp_i     = '0;
    in_shl_i     = 1'b0;
    in_shift_i   = '0;
    in_payload_i = '0;
    out_credit_i = 1'b0;
    seed         = 28787;
    prod_credits = `RND_QUEUE_DEPTH;
    pops         = 0;
    returns      = 0;
    sent         = 0;
    cyc          = 0;
    cur_test     = "reset";
    repeat (5) @(posedge cpu_clk);
    rst_n_i <= 1'b1;
    @(posedge cpu_clk);
    exact_floats();
    rounding_modes();
    exponent_range();
    int_conversion();
    credit_burst();
    // every op popped once and every credit returned
    if (exp_q.size() == 0 && pops == sent && returns == sent) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_failure("operations, pops and credits do not add up at the end of the run");
    end
  end

endmodule

// File: hdl/rnd_top.sv
`include "rnd_defs.svh"

module rnd_top (
  input  logic                      cpu_clk,
  input  logic                      rst_n_i,
  // operand side, credit based
  input  logic                      in_valid_i,
  input  logic                      in_kind_i,
  input  logic [1:0]                in_mode_i,
  input  logic                      in_sign_i,
  input  logic [`RND_EXP_INT_W-1:0] in_exp_i,
  input  logic                      in_shl_i,
  input  logic [`RND_SH_W-1:0]      in_shift_i,
  input  logic [`RND_INT_W+1:0]     in_payload_i,
  output logic                      in_credit_o,
  // result side, credit based
  output logic                      out_valid_o,
  output logic [`RND_INT_W-1:0]     out_result_o,
  output logic [5:0]                out_flags_o,
  input  logic                      out_credit_i
);

  rnd_op_if  op_if ();
  rnd_res_if res_if ();

  // queue and both credit counters
  rnd_issue_queue u_issue_queue (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .in_valid_i   (in_valid_i),
    .in_kind_i    (in_kind_i),
    .in_mode_i    (in_mode_i),
    .in_sign_i    (in_sign_i),
    .in_exp_i     (in_exp_i),
    .in_shl_i     (in_shl_i),
    .in_shift_i   (in_shift_i),
    .in_payload_i (in_payload_i),
    .in_credit_o  (in_credit_o),
    .out_credit_i (out_credit_i),
    .op           (op_if.src)
  );

  // float rounding
  rnd_fp_path u_fp_path (
    .cpu_clk (cpu_clk),
    .rst_n_i (rst_n_i),
    .op      (op_if.fp_sink),
    .res     (res_if.fp_src)
  );

  // float to int conversion
  rnd_int_path u_int_path (
    .cpu_clk (cpu_clk),
    .rst_n_i (rst_n_i),
    .op      (op_if.int_sink),
    .res     (res_if.int_src)
  );

  rnd_result_pack u_result_pack (
    .cpu_clk      (cpu_clk),
    .rst_n_i      (rst_n_i),
    .res          (res_if.sink),
    .out_valid_o  (out_valid_o),
    .out_result_o (out_result_o),
    .out_flags_o  (out_flags_o)
  );

endmodule

// File: hdl/rnd_result_pack.sv
`include "rnd_defs.svh"

module rnd_result_pack (
  input  logic                cpu_clk,
  input  logic                rst_n_i,
  rnd_res_if.sink             res,
  output logic                out_valid_o,
  output rnd_pkg::rnd_word_u  out_result_o,
  output rnd_pkg::rnd_flags_t out_flags_o
);

  rnd_pkg::rnd_word_u  pk_word;
  rnd_pkg::rnd_flags_t pk_flags;

  ////////////////////////////////////////////////////////////////////////////
  // encode, only one side is valid in a cycle
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    pk_word  = '0;
    pk_flags = '0;
    if (res.int_valid) begin
      // integer view, word as is
      pk_word.word = res.int_word;
      pk_flags.inv = res.int_inv;
      pk_flags.ine = res.int_lost;
      pk_flags.zer = (res.int_word == '0);
    end else begin
      pk_word.fp.sign = res.fp_sign;
      if (res.fp_exp > `RND_EXP_MAX) begin
        // overflow, signed infinity
        pk_word.fp.exp  = '1;
        pk_word.fp.mant = '0;
        pk_flags.ovf    = 1'b1;
        pk_flags.inf    = 1'b1;
        pk_flags.ine    = 1'b1;
      end else if (!res.fp_sig[`RND_SIG_W-1]) begin
        // no hidden bit, denormal or zero
        pk_word.fp.exp  = '0;
        pk_word.fp.mant = res.fp_sig[`RND_SIG_W-2:0];
        pk_flags.unf    = res.fp_lost;
        pk_flags.zer    = (res.fp_sig == '0);
      end else begin
        pk_word.fp.exp  = res.fp_exp[`RND_EXP_W-1:0];
        pk_word.fp.mant = res.fp_sig[`RND_SIG_W-2:0];
      end
      // any lost bit is inexact
      pk_flags.ine = pk_flags.ine | res.fp_lost;
    end
  end

  // output register
  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= res.fp_valid | res.int_valid;
    end
  end

  always_ff @(posedge cpu_clk) begin
    out_result_o <= pk_word;
    out_flags_o  <= pk_flags;
  end

endmodule

// File: hdl/rnd_int_path.sv
`include "rnd_defs.svh"

module rnd_int_path (
  input  logic        cpu_clk,
  input  logic        rst_n_i,
  rnd_op_if.int_sink  op,
  rnd_res_if.int_src  res
);

  // magnitude plus round and sticky
  localparam int IW = `RND_INT_W + 2;

  // stage 1, right shift
  logic [IW-1:0]         s1t_shr;
  logic [IW-1:0]         s1t_mask;
  logic                  s1_vld;
  rnd_pkg::rnd_mode_e    s1_mode;
  logic                  s1_sign;
  logic [`RND_INT_W-1:0] s1_mag;
  logic                  s1_r;
  logic                  s1_s;

  assign s1t_shr  = op.entry.payload >> op.entry.shift;
  assign s1t_mask = (IW'(1) << op.entry.shift) - IW'(1);

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= op.pop && (op.entry.kind == rnd_pkg::RND_KIND_F2I);
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (op.valid) begin
      s1_mode <= op.entry.mode;
      s1_sign <= op.entry.sign;
      s1_mag  <= s1t_shr[IW-1:2];
      s1_r    <= s1t_shr[1];
      // shifted-out bits and incoming sticky
      s1_s    <= s1t_shr[0] | (|(op.entry.payload & s1t_mask));
    end
  end

  // stage 2, round and range check
  logic                  s2t_up;
  logic [`RND_INT_W:0]   s2t_sum;
  logic                  s2t_inv;
  logic                  s2_vld;
  logic                  s2_sign;
  logic [`RND_INT_W-1:0] s2_mag;
  logic                  s2_inv;
  logic                  s2_lost;

  assign s2t_up  = rnd_pkg::rnd_round_up(s1_mode, s1_sign, s1_mag[0], s1_r, s1_s);
  assign s2t_sum = {1'b0, s1_mag} + {{`RND_INT_W{1'b0}}, s2t_up};
  // positive limit 2^31-1, negative limit 2^31
  assign s2t_inv = s2t_sum[`RND_INT_W] |
                   (s1_sign ? (s2t_sum[`RND_INT_W-1] & (|s2t_sum[`RND_INT_W-2:0]))
                            : s2t_sum[`RND_INT_W-1]);

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      s2_vld <= 1'b0;
    end else begin
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge cpu_clk) begin
    s2_sign <= s1_sign;
    s2_mag  <= s2t_sum[`RND_INT_W-1:0];
    s2_inv  <= s2t_inv;
    s2_lost <= s1_r | s1_s;
  end

  // stage 3, negate or saturate
  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      res.int_valid <= 1'b0;
    end else begin
      res.int_valid <= s2_vld;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (s2_inv) begin
      // most negative or most positive int
      res.int_word <= {s2_sign, {(`RND_INT_W-1){~s2_sign}}};
    end else begin
      res.int_word <= s2_sign ? (~s2_mag + 1'b1) : s2_mag;
    end
    res.int_inv  <= s2_inv;
    res.int_lost <= s2_lost;
  end

endmodule

// File: hdl/rnd_fp_path.sv
`include "rnd_defs.svh"

module rnd_fp_path (
  input  logic       cpu_clk,
  input  logic       rst_n_i,
  rnd_op_if.fp_sink  op,
  rnd_res_if.fp_src  res
);

  // significand plus round and sticky
  localparam int FW = `RND_SIG_W + 2;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, align
  ////////////////////////////////////////////////////////////////////////////

  logic [FW-1:0]             s1t_frac;
  logic [FW-1:0]             s1t_shr;
  logic [FW-1:0]             s1t_shl;
  logic [FW-1:0]             s1t_mask;
  logic                      s1t_stk;

  logic                      s1_vld;
  rnd_pkg::rnd_mode_e        s1_mode;
  logic                      s1_sign;
  logic [`RND_EXP_INT_W-1:0] s1_exp;
  logic [`RND_SIG_W-1:0]     s1_sig;
  logic                      s1_r;
  logic                      s1_s;

  assign s1t_frac = op.entry.payload[FW-1:0];
  assign s1t_shr  = s1t_frac >> op.entry.shift;
  assign s1t_shl  = s1t_frac << op.entry.shift;
  // bits that fall off the bottom on a right shift
  assign s1t_mask = (FW'(1) << op.entry.shift) - FW'(1);
  // incoming sticky sits at bit 0, so it is inside the mask
  assign s1t_stk  = s1t_shr[0] | (|(s1t_frac & s1t_mask));

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= op.pop && (op.entry.kind == rnd_pkg::RND_KIND_FP);
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (op.valid) begin
      s1_mode <= op.entry.mode;
      s1_sign <= op.entry.sign;
      s1_exp  <= op.entry.exp;
      if (op.entry.shl) begin
        // r and s move into the significand
        s1_sig <= s1t_shl[FW-1:2];
        s1_r   <= 1'b0;
        s1_s   <= 1'b0;
      end else begin
        s1_sig <= s1t_shr[FW-1:2];
        s1_r   <= s1t_shr[1];
        s1_s   <= s1t_stk;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, round
  ////////////////////////////////////////////////////////////////////////////

  logic                      s2t_up;
  logic                      s2_vld;
  logic                      s2_sign;
  logic [`RND_EXP_INT_W-1:0] s2_exp;
  // one extra bit for the carry
  logic [`RND_SIG_W:0]       s2_sig;
  logic                      s2_lost;

  assign s2t_up = rnd_pkg::rnd_round_up(s1_mode, s1_sign, s1_sig[0], s1_r, s1_s);

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      s2_vld <= 1'b0;
    end else begin
      s2_vld <= s1_vld;
    end
  end

  always_ff @(posedge cpu_clk) begin
    s2_sign <= s1_sign;
    s2_exp  <= s1_exp;
    s2_sig  <= {1'b0, s1_sig} + {{`RND_SIG_W{1'b0}}, s2t_up};
    s2_lost <= s1_r | s1_s;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 3, renormalize after carry
  ////////////////////////////////////////////////////////////////////////////

  logic s3t_carry;

  // all ones rounded up, becomes 1.0 x 2^(e+1)
  assign s3t_carry = s2_sig[`RND_SIG_W];

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      res.fp_valid <= 1'b0;
    end else begin
      res.fp_valid <= s2_vld;
    end
  end

  always_ff @(posedge cpu_clk) begin
    res.fp_sign <= s2_sign;
    res.fp_exp  <= s2_exp + {{(`RND_EXP_INT_W-1){1'b0}}, s3t_carry};
    res.fp_sig  <= s3t_carry ? s2_sig[`RND_SIG_W:1] : s2_sig[`RND_SIG_W-1:0];
    res.fp_lost <= s2_lost;
  end

endmodule

// File: hdl/rnd_issue_queue.sv
`include "rnd_defs.svh"

module rnd_issue_queue (
  input  logic                      cpu_clk,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  input  logic                      in_kind_i,
  input  logic [1:0]                in_mode_i,
  input  logic                      in_sign_i,
  input  logic [`RND_EXP_INT_W-1:0] in_exp_i,
  input  logic                      in_shl_i,
  input  logic [`RND_SH_W-1:0]      in_shift_i,
  input  logic [`RND_INT_W+1:0]     in_payload_i,
  output logic                      in_credit_o,
  input  logic                      out_credit_i,
  rnd_op_if.src                     op
);

  localparam int PTR_W = $clog2(`RND_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`RND_QUEUE_DEPTH + 1);
  localparam int CRD_W = $clog2(`RND_OUT_CREDITS + 1);

  rnd_pkg::rnd_op_t q_mem [`RND_QUEUE_DEPTH];
  rnd_pkg::rnd_op_t in_entry;
  logic [PTR_W-1:0] q_wr;
  logic [PTR_W-1:0] q_rd;
  logic [CNT_W-1:0] q_cnt;
  logic [CRD_W-1:0] out_crd;
  logic             do_push;
  logic             do_pop;

  // gather the operand ports into one entry
  always_comb begin
    in_entry.kind    = rnd_pkg::rnd_kind_e'(in_kind_i);
    in_entry.mode    = rnd_pkg::rnd_mode_e'(in_mode_i);
    in_entry.sign    = in_sign_i;
    in_entry.exp     = in_exp_i;
    in_entry.shl     = in_shl_i;
    in_entry.shift   = in_shift_i;
    in_entry.payload = in_payload_i;
  end

  // producer only sends with a credit in hand, so no full check
  assign do_push = in_valid_i;
  // issue needs an entry and a free output slot
  assign do_pop  = (q_cnt != '0) && (out_crd != '0);

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk) begin
    if (do_push) begin
      q_mem[q_wr] <= in_entry;
    end
  end

  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      q_wr  <= '0;
      q_rd  <= '0;
      q_cnt <= '0;
    end else begin
      // wrap at depth
      if (do_push) begin
        q_wr <= (q_wr == PTR_W'(`RND_QUEUE_DEPTH - 1)) ? '0 : q_wr + 1'b1;
      end
      if (do_pop) begin
        q_rd <= (q_rd == PTR_W'(`RND_QUEUE_DEPTH - 1)) ? '0 : q_rd + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output credits
  ////////////////////////////////////////////////////////////////////////////

  // spent at pop, returned by the consumer, both may land together
  always_ff @(posedge cpu_clk) begin
    if (!rst_n_i) begin
      out_crd <= CRD_W'(`RND_OUT_CREDITS);
    end else begin
      case ({out_credit_i, do_pop})
        2'b10:   out_crd <= out_crd + 1'b1;
        2'b01:   out_crd <= out_crd - 1'b1;
        default: out_crd <= out_crd;
      endcase
    end
  end

  // head entry straight to the paths
  assign op.valid    = (q_cnt != '0);
  assign op.entry    = q_mem[q_rd];
  assign op.pop      = do_pop;
  // one input credit per entry leaving
  assign in_credit_o = do_pop;

endmodule

// File: hdl/rnd_ifs.sv
`include "rnd_defs.svh"

// queue to both paths
interface rnd_op_if;

  // head of queue holds an entry
  logic                valid;
  // head entry
  rnd_pkg::rnd_op_t    entry;
  // head leaves the queue at the next edge
  logic                pop;

  modport src     (output valid, output entry, output pop);
  modport fp_sink (input valid, input entry, input pop);
  modport int_sink(input valid, input entry, input pop);

endinterface

// both paths to the packer
interface rnd_res_if;

  // float side, unpacked
  logic                      fp_valid;
  logic                      fp_sign;
  logic [`RND_EXP_INT_W-1:0] fp_exp;
  logic [`RND_SIG_W-1:0]     fp_sig;
  logic                      fp_lost;

  // integer side, already two's complement
  logic                      int_valid;
  logic [`RND_INT_W-1:0]     int_word;
  logic                      int_inv;
  logic                      int_lost;

  modport fp_src (output fp_valid, output fp_sign, output fp_exp, output fp_sig,
                  output fp_lost);
  modport int_src(output int_valid, output int_word, output int_inv, output int_lost);
  modport sink   (input fp_valid, input fp_sign, input fp_exp, input fp_sig,
                  input fp_lost, input int_valid, input int_word, input int_inv,
                  input int_lost);

endinterface

// File: hdl/rnd_pkg.sv
`include "rnd_defs.svh"

package rnd_pkg;

  // which path an entry goes to
  typedef enum logic [0:0] {
    RND_KIND_FP  = 1'b0,
    RND_KIND_F2I = 1'b1
  } rnd_kind_e;

  typedef enum logic [1:0] {
    RND_RNE = 2'd0,  // nearest, ties to even
    RND_RTZ = 2'd1,  // toward zero
    RND_RUP = 2'd2,  // toward +inf
    RND_RDN = 2'd3   // toward -inf
  } rnd_mode_e;

  // exception flags, msb first
  typedef struct packed {
    logic inv;
    logic ine;
    logic ovf;
    logic unf;
    logic inf;
    logic zer;
  } rnd_flags_t;

  // ieee single fields
  typedef struct packed {
    logic                  sign;
    logic [`RND_EXP_W-1:0] exp;
    logic [`RND_SIG_W-2:0] mant;
  } rnd_fp_word_t;

  // float fields or plain integer, same 32 bits
  typedef union packed {
    rnd_fp_word_t           fp;
    logic [`RND_INT_W-1:0]  word;
  } rnd_word_u;

  // queue entry
  typedef struct packed {
    rnd_kind_e                 kind;
    rnd_mode_e                 mode;
    logic                      sign;
    logic [`RND_EXP_INT_W-1:0] exp;
    logic                      shl;
    logic [`RND_SH_W-1:0]      shift;
    // magnitude, then round, then sticky
    logic [`RND_INT_W+1:0]     payload;
  } rnd_op_t;

  // round-up decision, common to both paths
  function automatic logic rnd_round_up(rnd_mode_e mode, logic sign, logic lsb,
                                        logic rnd, logic stk);
    logic up;
    case (mode)
      RND_RNE: up = rnd & (stk | lsb);
      RND_RTZ: up = 1'b0;
      RND_RUP: up = ~sign & (rnd | stk);
      RND_RDN: up = sign & (rnd | stk);
      default: up = 1'b0;
    endcase
    return up;
  endfunction

endpackage

// File: hdl/rnd_defs.svh
`ifndef RND_DEFS_SVH
`define RND_DEFS_SVH

// binary32 field widths
`define RND_EXP_W        8
// internal exponent, two spare bits to catch overflow
`define RND_EXP_INT_W    10
// significand including the hidden bit
`define RND_SIG_W        24
// integer result and packed word width
`define RND_INT_W        32
// pre-shift amount
`define RND_SH_W         5
// largest biased exponent that is still finite
`define RND_EXP_MAX      254

// flow control
`define RND_QUEUE_DEPTH  4
`define RND_OUT_CREDITS  4

`endif
